// ==== hdl/periph_pkg.sv ====
package periph_pkg;

    // ------------------------------------------------------------------------
    // bus widths
    // ------------------------------------------------------------------------
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // word index inside one peripheral
    typedef logic [2:0]  reg_idx_t;

    // peripheral region number
    typedef logic [3:0]  region_t;

    // address fields
    localparam int RegionMsb = 15;
    localparam int RegionLsb = 12;
    localparam int IdxMsb    = 4;
    localparam int IdxLsb    = 2;

    // ------------------------------------------------------------------------
    // region map
    // ------------------------------------------------------------------------
    localparam region_t RegionIrq   = 4'd0;
    localparam region_t RegionUart  = 4'd1;
    localparam region_t RegionTimer = 4'd2;

    // read data for holes in the map
    localparam data_t FillerWord = 32'hdeadbeef;

    // uart transmitter states
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_t;

endpackage

// ==== hdl/periph_decoder.sv ====
`timescale 1ns/1ps

module periph_decoder import periph_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,
    // request channel
    input  logic     req_valid_i,
    input  addr_t    req_addr_i,
    input  logic     req_write_i,
    input  data_t    req_wdata_i,
    output logic     req_ready_o,
    // response channel
    output logic     rsp_valid_o,
    output data_t    rsp_rdata_o,
    output logic     rsp_error_o,
    input  logic     rsp_ready_i,
    // peripheral side
    output logic     sel_irq_o,
    output logic     sel_uart_o,
    output logic     sel_timer_o,
    output logic     wr_o,
    output reg_idx_t idx_o,
    output data_t    wdata_o,
    input  data_t    rdata_irq_i,
    input  data_t    rdata_uart_i,
    input  data_t    rdata_timer_i,
    input  logic     err_irq_i,
    input  logic     err_uart_i,
    input  logic     err_timer_i
);

    logic    rsp_valid_q;
    data_t   rsp_rdata_q;
    logic    rsp_error_q;
    region_t region;
    logic    accept;
    data_t   sel_rdata;
    logic    sel_err;

    // one transaction in flight at most
    assign req_ready_o = ~rsp_valid_q;
    assign accept      = req_valid_i & req_ready_o;
    assign region      = req_addr_i[RegionMsb:RegionLsb];

    // strobes last for the accept cycle only
    assign sel_irq_o   = accept && (region == RegionIrq);
    assign sel_uart_o  = accept && (region == RegionUart);
    assign sel_timer_o = accept && (region == RegionTimer);

    assign wr_o    = req_write_i;
    assign idx_o   = req_addr_i[IdxMsb:IdxLsb];
    assign wdata_o = req_wdata_i;

    // unmapped regions answer with the filler word and an error
    always_comb begin
        sel_rdata = FillerWord;
        sel_err   = 1'b1;
        case (region)
            RegionIrq: begin
                sel_rdata = rdata_irq_i;
                sel_err   = err_irq_i;
            end
            RegionUart: begin
                sel_rdata = rdata_uart_i;
                sel_err   = err_uart_i;
            end
            RegionTimer: begin
                sel_rdata = rdata_timer_i;
                sel_err   = err_timer_i;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (accept) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    // response payload, captured once per request
    always_ff @(posedge clk_i) begin
        if (accept) begin
            rsp_rdata_q <= req_write_i ? '0 : sel_rdata;
            rsp_error_q <= sel_err;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_rdata_o = rsp_rdata_q;
    assign rsp_error_o = rsp_error_q;

endmodule

// ==== hdl/irq_ctrl.sv ====
`timescale 1ns/1ps

module irq_ctrl import periph_pkg::*; #(
    parameter int TimerCnt  = 2,
    parameter int PrioWidth = 2
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              sel_i,
    input  logic              wr_i,
    input  reg_idx_t          idx_i,
    input  data_t             wdata_i,
    output data_t             rdata_o,
    output logic              err_o,
    input  logic [TimerCnt:0] src_i,
    output logic              irq_o
);

    localparam int       SrcCnt       = 1 + TimerCnt;
    localparam int       IdWidth      = $clog2(SrcCnt + 1);
    localparam reg_idx_t IdxEnable    = 3'd0;
    localparam reg_idx_t IdxThreshold = 3'd1;
    localparam int       IdxPrio      = 2;
    localparam reg_idx_t IdxClaim     = 3'd7;

    typedef logic [PrioWidth-1:0] prio_t;
    typedef logic [IdWidth-1:0]   src_id_t;

    logic [SrcCnt-1:0] enable_q;
    logic [SrcCnt-1:0] pending_q;
    logic [SrcCnt-1:0] in_service_q;
    prio_t             threshold_q;
    prio_t             prio_q [SrcCnt];
    src_id_t           best_id;
    prio_t             best_prio;
    logic              claim;
    logic              complete;
    logic [SrcCnt-1:0] claim_mask;
    logic [SrcCnt-1:0] complete_mask;
    logic [SrcCnt-1:0] gate_set;

    // ------------------------------------------------------------------------
    // highest priority pending source above threshold
    // ------------------------------------------------------------------------
    always_comb begin
        best_id   = '0;
        best_prio = threshold_q;
        // strict compare keeps the lower source on a tie
        for (int i = 0; i < SrcCnt; i++) begin
            if (pending_q[i] && enable_q[i] && (prio_q[i] > best_prio)) begin
                best_id   = src_id_t'(i + 1);
                best_prio = prio_q[i];
            end
        end
    end

    assign irq_o = (best_id != '0);

    assign claim    = sel_i & ~wr_i & (idx_i == IdxClaim);
    assign complete = sel_i & wr_i & (idx_i == IdxClaim);

    always_comb begin
        claim_mask    = '0;
        complete_mask = '0;
        for (int i = 0; i < SrcCnt; i++) begin
            claim_mask[i]    = claim && (best_id == src_id_t'(i + 1));
            complete_mask[i] = complete && (wdata_i == data_t'(i + 1));
        end
    end

    // level gateways, blocked while in service
    assign gate_set = src_i & ~in_service_q;

    // register read mux
    always_comb begin
        rdata_o = '0;
        err_o   = 1'b0;
        if (idx_i == IdxClaim) begin
            rdata_o = data_t'(best_id);
        end else if (idx_i == IdxEnable) begin
            rdata_o = data_t'(enable_q);
        end else if (idx_i == IdxThreshold) begin
            rdata_o = data_t'(threshold_q);
        end else if (int'(idx_i) >= IdxPrio && int'(idx_i) < IdxPrio + SrcCnt) begin
            rdata_o = data_t'(prio_q[int'(idx_i) - IdxPrio]);
        end else begin
            err_o = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            enable_q     <= '0;
            threshold_q  <= '0;
            pending_q    <= '0;
            in_service_q <= '0;
            for (int i = 0; i < SrcCnt; i++) begin
                prio_q[i] <= '0;
            end
        end else begin
            pending_q    <= (pending_q | gate_set) & ~claim_mask;
            in_service_q <= (in_service_q | claim_mask) & ~complete_mask;
            if (sel_i && wr_i && !err_o) begin
                if (idx_i == IdxEnable) begin
                    enable_q <= wdata_i[SrcCnt-1:0];
                end
                if (idx_i == IdxThreshold) begin
                    threshold_q <= wdata_i[PrioWidth-1:0];
                end
                for (int i = 0; i < SrcCnt; i++) begin
                    if (int'(idx_i) == IdxPrio + i) begin
                        prio_q[i] <= wdata_i[PrioWidth-1:0];
                    end
                end
            end
        end
    end

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx import periph_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     sel_i,
    input  logic     wr_i,
    input  reg_idx_t idx_i,
    input  data_t    wdata_i,
    output data_t    rdata_o,
    output logic     err_o,
    output logic     tx_o,
    output logic     irq_o
);

    localparam reg_idx_t IdxData   = 3'd0;
    localparam reg_idx_t IdxStatus = 3'd1;
    localparam reg_idx_t IdxCtrl   = 3'd2;
    localparam reg_idx_t IdxDiv    = 3'd3;
    localparam data_t    DivReset  = 32'd16;

    uart_state_t state_q;
    data_t       div_q;
    data_t       cyc_cnt_q;
    logic [2:0]  bit_cnt_q;
    logic [7:0]  shift_q;
    logic        tx_q;
    logic        irq_en_q;
    logic        busy;
    logic        bit_end;
    logic        wr_ok;

    assign busy    = (state_q != UART_IDLE);
    assign bit_end = (cyc_cnt_q >= div_q - 1);
    assign tx_o    = tx_q;
    assign irq_o   = irq_en_q & ~busy;

    // status holds busy in bit 0 and the fsm state in bits 2:1
    always_comb begin
        rdata_o = '0;
        err_o   = 1'b0;
        case (idx_i)
            IdxData:   err_o = wr_i & busy;
            IdxStatus: rdata_o = data_t'({state_q, busy});
            IdxCtrl:   rdata_o = data_t'(irq_en_q);
            IdxDiv: begin
                rdata_o = div_q;
                err_o   = wr_i && (wdata_i < 32'd2);
            end
            default:   err_o = 1'b1;
        endcase
    end

    assign wr_ok = sel_i & wr_i & ~err_o;

    // ------------------------------------------------------------------------
    // frame fsm, one bit every div_q cycles
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= UART_IDLE;
            div_q     <= DivReset;
            cyc_cnt_q <= '0;
            bit_cnt_q <= '0;
            shift_q   <= '0;
            tx_q      <= 1'b1;
            irq_en_q  <= 1'b0;
        end else begin
            if (wr_ok && idx_i == IdxCtrl) begin
                irq_en_q <= wdata_i[0];
            end
            if (wr_ok && idx_i == IdxDiv) begin
                div_q <= wdata_i;
            end
            if (wr_ok && idx_i == IdxData) begin
                state_q   <= UART_START;
                shift_q   <= wdata_i[7:0];
                cyc_cnt_q <= '0;
                bit_cnt_q <= '0;
                tx_q      <= 1'b0;
            end else if (busy) begin
                if (bit_end) begin
                    cyc_cnt_q <= '0;
                    case (state_q)
                        UART_START: begin
                            state_q <= UART_DATA;
                            tx_q    <= shift_q[0];
                        end
                        UART_DATA: begin
                            shift_q   <= {1'b0, shift_q[7:1]};
                            bit_cnt_q <= bit_cnt_q + 3'd1;
                            if (bit_cnt_q == 3'd7) begin
                                state_q <= UART_STOP;
                                tx_q    <= 1'b1;
                            end else begin
                                tx_q <= shift_q[1];
                            end
                        end
                        default: state_q <= UART_IDLE;
                    endcase
                end else begin
                    cyc_cnt_q <= cyc_cnt_q + 32'd1;
                end
            end
        end
    end

endmodule

// ==== hdl/timer_bank.sv ====
`timescale 1ns/1ps

module timer_bank import periph_pkg::*; #(
    parameter int TimerCnt = 2
) (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                sel_i,
    input  logic                wr_i,
    input  reg_idx_t            idx_i,
    input  data_t               wdata_i,
    output data_t               rdata_o,
    output logic                err_o,
    output logic [TimerCnt-1:0] irq_o
);

    // word offsets inside one timer's group of four
    localparam logic [1:0] RegCtrl  = 2'd0;
    localparam logic [1:0] RegCount = 2'd1;
    localparam logic [1:0] RegCmp   = 2'd2;

    logic [TimerCnt-1:0] en_q;
    logic [TimerCnt-1:0] flag_q;
    logic [TimerCnt-1:0] match;
    data_t               count_q [TimerCnt];
    data_t               cmp_q [TimerCnt];
    int                  tsel;
    logic [1:0]          treg;
    logic                wr_ok;

    assign tsel  = int'(idx_i[2]);
    assign treg  = idx_i[1:0];
    assign irq_o = flag_q;

    always_comb begin
        for (int k = 0; k < TimerCnt; k++) begin
            match[k] = en_q[k] && (count_q[k] == cmp_q[k]);
        end
    end

    always_comb begin
        rdata_o = '0;
        err_o   = 1'b0;
        if (tsel >= TimerCnt) begin
            err_o = 1'b1;
        end else begin
            case (treg)
                RegCtrl:  rdata_o = data_t'({flag_q[tsel], en_q[tsel]});
                RegCount: rdata_o = count_q[tsel];
                RegCmp:   rdata_o = cmp_q[tsel];
                default:  err_o = 1'b1;
            endcase
        end
    end

    assign wr_ok = sel_i & wr_i & ~err_o;

    // ------------------------------------------------------------------------
    // counters and register writes
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            en_q   <= '0;
            flag_q <= '0;
            for (int k = 0; k < TimerCnt; k++) begin
                count_q[k] <= '0;
                cmp_q[k]   <= '0;
            end
        end else begin
            for (int k = 0; k < TimerCnt; k++) begin
                if (match[k]) begin
                    count_q[k] <= '0;
                    flag_q[k]  <= 1'b1;
                end else if (en_q[k]) begin
                    count_q[k] <= count_q[k] + 32'd1;
                end
                if (wr_ok && tsel == k) begin
                    case (treg)
                        RegCtrl: begin
                            en_q[k] <= wdata_i[0];
                            // write one to clear, a fresh match wins
                            if (wdata_i[1] && !match[k]) begin
                                flag_q[k] <= 1'b0;
                            end
                        end
                        RegCount: count_q[k] <= wdata_i;
                        RegCmp:   cmp_q[k] <= wdata_i;
                        default: ;
                    endcase
                end
            end
        end
    end

endmodule

// ==== hdl/periph_top.sv ====
`timescale 1ns/1ps

module periph_top import periph_pkg::*; #(
    parameter int TimerCnt  = 2,
    parameter int PrioWidth = 2
) (
    input  logic  clk_i,
    input  logic  arst_n_i,
    // register bus
    input  logic  req_valid_i,
    input  addr_t req_addr_i,
    input  logic  req_write_i,
    input  data_t req_wdata_i,
    output logic  req_ready_o,
    output logic  rsp_valid_o,
    output data_t rsp_rdata_o,
    output logic  rsp_error_o,
    input  logic  rsp_ready_i,
    // uart line and interrupt
    output logic  tx_o,
    output logic  irq_o
);

    logic sel_irq, sel_uart, sel_timer;
    logic wr;
    reg_idx_t idx;
    data_t wdata;
    data_t rdata_irq, rdata_uart, rdata_timer;
    logic err_irq, err_uart, err_timer;

    // source 0 is the uart, timers follow
    logic [TimerCnt:0] irq_src;

    // ------------------------------------------------------------------------
    // address decoder
    // ------------------------------------------------------------------------
    periph_decoder i_decoder (
        .clk_i, .arst_n_i,
        .req_valid_i, .req_addr_i, .req_write_i, .req_wdata_i, .req_ready_o,
        .rsp_valid_o, .rsp_rdata_o, .rsp_error_o, .rsp_ready_i,
        .sel_irq_o     ( sel_irq     ),
        .sel_uart_o    ( sel_uart    ),
        .sel_timer_o   ( sel_timer   ),
        .wr_o          ( wr          ),
        .idx_o         ( idx         ),
        .wdata_o       ( wdata       ),
        .rdata_irq_i   ( rdata_irq   ),
        .rdata_uart_i  ( rdata_uart  ),
        .rdata_timer_i ( rdata_timer ),
        .err_irq_i     ( err_irq     ),
        .err_uart_i    ( err_uart    ),
        .err_timer_i   ( err_timer   )
    );

    // ------------------------------------------------------------------------
    // peripherals
    // ------------------------------------------------------------------------
    irq_ctrl #(.TimerCnt(TimerCnt), .PrioWidth(PrioWidth)) i_irq_ctrl (
        .clk_i, .arst_n_i,
        .sel_i(sel_irq), .wr_i(wr), .idx_i(idx), .wdata_i(wdata),
        .rdata_o(rdata_irq), .err_o(err_irq), .src_i(irq_src), .irq_o
    );

    uart_tx i_uart_tx (
        .clk_i, .arst_n_i,
        .sel_i(sel_uart), .wr_i(wr), .idx_i(idx), .wdata_i(wdata),
        .rdata_o(rdata_uart), .err_o(err_uart), .tx_o, .irq_o(irq_src[0])
    );

    timer_bank #(.TimerCnt(TimerCnt)) i_timer_bank (
        .clk_i, .arst_n_i,
        .sel_i(sel_timer), .wr_i(wr), .idx_i(idx), .wdata_i(wdata),
        .rdata_o(rdata_timer), .err_o(err_timer), .irq_o(irq_src[TimerCnt:1])
    );

endmodule

// ==== test/periph_props.sv ====
`timescale 1ns/1ps

module periph_props import periph_pkg::*; (
    input logic  clk_i,
    input logic  arst_n_i,
    input logic  req_ready_o,
    input logic  rsp_valid_o,
    input data_t rsp_rdata_o,
    input logic  rsp_error_o,
    input logic  rsp_ready_i
);

    int unsigned fail_cnt = 0;

    // a held response stays valid until the host takes it
    valid_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o)
        else begin
            fail_cnt++;
            $error("rsp_valid_o dropped before rsp_ready_i");
        end

    // payload frozen while held
    fields_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rsp_valid_o && !rsp_ready_i |=> $stable(rsp_rdata_o) && $stable(rsp_error_o))
        else begin
            fail_cnt++;
            $error("response fields changed while held");
        end

    no_new_request: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rsp_valid_o |-> !req_ready_o)
        else begin
            fail_cnt++;
            $error("req_ready_o high while a response is held");
        end

endmodule

bind periph_decoder periph_props i_props (.*);

// ==== test/tb_periph_top.sv ====
`timescale 1ns/1ps

module tb_periph_top import periph_pkg::*; ();

    localparam int Timeout = 200;
    localparam int UartDiv = 4;

    logic        clk;
    logic        arst_n;
    logic        req_valid;
    addr_t       req_addr;
    logic        req_write;
    data_t       req_wdata;
    logic        req_ready;
    logic        rsp_valid;
    data_t       rsp_rdata;
    logic        rsp_error;
    logic        rsp_ready;
    logic        tx;
    logic        irq;
    logic [15:0] lfsr;
    int          errors;
    int          checks;

    periph_top #(.TimerCnt(2), .PrioWidth(2)) dut (
        .clk_i(clk), .arst_n_i(arst_n),
        .req_valid_i(req_valid), .req_addr_i(req_addr), .req_write_i(req_write),
        .req_wdata_i(req_wdata), .req_ready_o(req_ready),
        .rsp_valid_o(rsp_valid), .rsp_rdata_o(rsp_rdata), .rsp_error_o(rsp_error),
        .rsp_ready_i(rsp_ready), .tx_o(tx), .irq_o(irq)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic addr_t reg_addr(input region_t region, input int idx);
        return (addr_t'(region) << 12) | (addr_t'(idx) << 2);
    endfunction

    // ------------------------------------------------------------------------
    // checks and waits
    // ------------------------------------------------------------------------
    task automatic check(input string name, input data_t got, input data_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL time=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL time=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("error at time %0t: %s", $time, what);
    endtask

    // inputs change 1 ns after the edge
    task automatic tick(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_irq();
        int t;
        t = 0;
        while (!irq && t < Timeout) begin
            tick(1);
            t++;
        end
        if (!irq) report_error("timed out waiting for irq_o to rise");
    endtask

    // ------------------------------------------------------------------------
    // bus transfers
    // ------------------------------------------------------------------------
    task automatic bus_xfer(input logic wr, input addr_t addr, input data_t wd,
                            input int hold, output data_t rd, output logic err);
        int t;
        req_valid = 1'b1;
        req_addr  = addr;
        req_write = wr;
        req_wdata = wd;
        rsp_ready = (hold == 0);
        t = 0;
        while (!req_ready && t < Timeout) begin
            tick(1);
            t++;
        end
        if (!req_ready) report_error("timed out waiting for req_ready_o");
        tick(1);
        req_valid = 1'b0;
        t = 0;
        while (!rsp_valid && t < Timeout) begin
            tick(1);
            t++;
        end
        if (!rsp_valid) report_error("timed out waiting for rsp_valid_o");
        rd  = rsp_rdata;
        err = rsp_error;
        // back-pressure, the response must stay put
        for (int i = 0; i < hold; i++) begin
            tick(1);
            check_bit("rsp_valid_o (held)", rsp_valid, 1'b1);
            check("rsp_rdata_o (held)", rsp_rdata, rd);
            check_bit("req_ready_o (held)", req_ready, 1'b0);
        end
        rsp_ready = 1'b1;
        tick(1);
        check_bit("rsp_valid_o (after handshake)", rsp_valid, 1'b0);
    endtask

    task automatic bus_write(input addr_t addr, input data_t wd, input logic exp_err);
        data_t rd;
        logic  err;
        bus_xfer(1'b1, addr, wd, 0, rd, err);
        check("rsp_rdata_o (write)", rd, 32'd0);
        check_bit("rsp_error_o (write)", err, exp_err);
    endtask

    task automatic bus_read(input addr_t addr, output data_t rd, output logic err);
        bus_xfer(1'b0, addr, '0, 0, rd, err);
    endtask

    task automatic read_check(input string name, input addr_t addr, input data_t exp,
                              input logic exp_err);
        data_t rd;
        logic  err;
        bus_read(addr, rd, err);
        check({"rsp_rdata_o ", name}, rd, exp);
        check_bit({"rsp_error_o ", name}, err, exp_err);
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic test_reset();
        check_bit("req_ready_o", req_ready, 1'b1);
        check_bit("rsp_valid_o", rsp_valid, 1'b0);
        check_bit("irq_o", irq, 1'b0);
        check_bit("tx_o", tx, 1'b1);
        read_check("(timer0 count)", reg_addr(RegionTimer, 1), 32'd0, 1'b0);
        read_check("(uart divider)", reg_addr(RegionUart, 3), 32'd16, 1'b0);
    endtask

    task automatic test_unmapped();
        data_t rd;
        logic  err;
        read_check("(region 5)", reg_addr(4'd5, 0), FillerWord, 1'b1);
        bus_write(reg_addr(4'd5, 0), 32'h1234, 1'b1);
        bus_read(reg_addr(RegionTimer, 3), rd, err);
        check_bit("rsp_error_o (timer index 3)", err, 1'b1);
    endtask

    task automatic test_backpressure();
        data_t rd;
        logic  err;
        bus_xfer(1'b0, reg_addr(RegionUart, 3), '0, 10, rd, err);
        check("rsp_rdata_o (divider under hold)", rd, 32'd16);
        check_bit("rsp_error_o (divider under hold)", err, 1'b0);
    endtask

    task automatic test_uart();
        data_t      rd;
        logic       err;
        logic [7:0] tx_byte;
        int         t;
        bus_write(reg_addr(RegionUart, 3), data_t'(UartDiv), 1'b0);
        for (int i = 0; i < 8; i++) begin
            lfsr       = lfsr_step(lfsr);
            tx_byte[i] = lfsr[0];
        end
        req_valid = 1'b1;
        req_addr  = reg_addr(RegionUart, 0);
        req_write = 1'b1;
        req_wdata = data_t'(tx_byte);
        t = 0;
        while (tx && t < Timeout) begin
            tick(1);
            t++;
        end
        if (tx) report_error("timed out waiting for the start bit on tx_o");
        req_valid = 1'b0;
        check_bit("rsp_error_o (uart data)", rsp_error, 1'b0);
        // now at the first edge of the start bit
        tick(UartDiv / 2);
        check_bit("tx_o (start bit)", tx, 1'b0);
        for (int i = 0; i < 8; i++) begin
            tick(UartDiv);
            check_bit("tx_o (data bit)", tx, tx_byte[i]);
        end
        tick(UartDiv);
        check_bit("tx_o (stop bit)", tx, 1'b1);
        bus_write(reg_addr(RegionUart, 0), 32'h55, 1'b1);
        tick(2);
        bus_read(reg_addr(RegionUart, 1), rd, err);
        check_bit("rsp_rdata_o[0] (uart busy)", rd[0], 1'b0);
    endtask

    task automatic test_timer_claim();
        bus_write(reg_addr(RegionIrq, 0), 32'b010, 1'b0);
        bus_write(reg_addr(RegionIrq, 3), 32'd1, 1'b0);
        bus_write(reg_addr(RegionIrq, 1), 32'd0, 1'b0);
        bus_write(reg_addr(RegionTimer, 2), 32'd20, 1'b0);
        bus_write(reg_addr(RegionTimer, 0), 32'd1, 1'b0);
        wait_irq();
        read_check("(claim)", reg_addr(RegionIrq, 7), 32'd2, 1'b0);
        check_bit("irq_o (after claim)", irq, 1'b0);
        bus_write(reg_addr(RegionTimer, 0), 32'd3, 1'b0);
        bus_write(reg_addr(RegionIrq, 7), 32'd2, 1'b0);
        check_bit("irq_o (after complete)", irq, 1'b0);
        // next match raises it again
        wait_irq();
        read_check("(second claim)", reg_addr(RegionIrq, 7), 32'd2, 1'b0);
        bus_write(reg_addr(RegionTimer, 0), 32'd2, 1'b0);
        bus_write(reg_addr(RegionIrq, 7), 32'd2, 1'b0);
    endtask

    task automatic test_priority();
        data_t rd;
        logic  err;
        int    t;
        bus_write(reg_addr(RegionIrq, 0), 32'b110, 1'b0);
        bus_write(reg_addr(RegionIrq, 3), 32'd1, 1'b0);
        bus_write(reg_addr(RegionIrq, 4), 32'd3, 1'b0);
        bus_write(reg_addr(RegionTimer, 2), 32'd10, 1'b0);
        bus_write(reg_addr(RegionTimer, 6), 32'd10, 1'b0);
        bus_write(reg_addr(RegionTimer, 0), 32'd3, 1'b0);
        bus_write(reg_addr(RegionTimer, 4), 32'd3, 1'b0);
        wait_irq();
        // let the later timer reach its compare as well
        t = 0;
        bus_read(reg_addr(RegionTimer, 4), rd, err);
        while (!rd[1] && t < Timeout) begin
            bus_read(reg_addr(RegionTimer, 4), rd, err);
            t++;
        end
        if (!rd[1]) report_error("timed out waiting for the timer 1 match flag");
        read_check("(first claim)", reg_addr(RegionIrq, 7), 32'd3, 1'b0);
        read_check("(second claim)", reg_addr(RegionIrq, 7), 32'd2, 1'b0);
        check_bit("irq_o (both in service)", irq, 1'b0);
        bus_write(reg_addr(RegionTimer, 0), 32'd0, 1'b0);
        bus_write(reg_addr(RegionTimer, 4), 32'd0, 1'b0);
        bus_write(reg_addr(RegionTimer, 0), 32'd2, 1'b0);
        bus_write(reg_addr(RegionTimer, 4), 32'd2, 1'b0);
        bus_write(reg_addr(RegionIrq, 7), 32'd3, 1'b0);
        bus_write(reg_addr(RegionIrq, 7), 32'd2, 1'b0);
        read_check("(idle claim)", reg_addr(RegionIrq, 7), 32'd0, 1'b0);
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        lfsr      = 16'd87;
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req_addr  = '0;
        req_write = 1'b0;
        req_wdata = '0;
        rsp_ready = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        test_reset();
        test_unmapped();
        test_backpressure();
        test_uart();
        test_timer_claim();
        test_priority();
        $display("checks: %0d  errors: %0d  assertion failures: %0d",
                 checks, errors, dut.i_decoder.i_props.fail_cnt);
        if (errors == 0 && dut.i_decoder.i_props.fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
hdl/periph_pkg.sv
hdl/periph_decoder.sv
hdl/irq_ctrl.sv
hdl/uart_tx.sv
hdl/timer_bank.sv
hdl/periph_top.sv
test/periph_props.sv
test/tb_periph_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f compile.f --top-module tb_periph_top -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_periph_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1
